/* common/link_pkg.sv */
package link_pkg;

    ////////////////////////////////
    // Link payload
    ////////////////////////////////

    // Width of the digit carried on link_data
    localparam int LINK_DATA_W = 3;

    // One switch index, 0 to 7
    typedef logic [LINK_DATA_W-1:0] link_data_t;

    ////////////////////////////////
    // Controller states
    ////////////////////////////////

    // Master side of the handshake
    typedef enum logic [1:0] {
        // Idle, waiting for a button press
        M_WAIT_RQST,
        // request2s held until the slave answers
        M_WAIT_ACK,
        // Notice LED lit for the hold period
        M_HOLD_NOTICE,
        // valid and link_data held until the receipt ack
        M_SEND_DATA
    } master_state_t;

    // Slave side of the handshake
    typedef enum logic [1:0] {
        S_WAIT_RQST,
        // Notice LED lit, ack follows at the end of the hold
        S_HOLD_NOTICE,
        S_WAIT_DATA
    } slave_state_t;

endpackage

/* common/board_pkg.sv */
package board_pkg;

    ////////////////////////////////
    // Board I/O widths
    ////////////////////////////////

    // Slide switches, one per digit
    localparam int NUM_SWITCHES = 8;

    // Segments a to g, no decimal point
    localparam int NUM_SEGMENTS = 7;

    ////////////////////////////////
    // Board I/O types
    ////////////////////////////////

    // Raw switch inputs, expected one-hot
    typedef logic [NUM_SWITCHES-1:0] switch_t;

    // A digit as one line per value
    typedef logic [NUM_SWITCHES-1:0] onehot_digit_t;

    // Active low segment drive
    // Bit 0 is segment a, bit 6 is segment g
    typedef logic [NUM_SEGMENTS-1:0] seg_t;

endpackage

/* rtl/hold_timer.sv */
`timescale 1ns/1ps

module hold_timer #(
    parameter int unsigned HOLD_CYCLES = 100_000_000
) (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    // Counter just wide enough for the last count
    localparam int CNT_W = (HOLD_CYCLES > 0) ? $clog2(HOLD_CYCLES + 1) : 1;
    localparam logic [CNT_W-1:0] LAST_COUNT = CNT_W'(HOLD_CYCLES);

    logic [CNT_W-1:0] count;

    // End of interval, only while start is held
    assign done = start && (count == LAST_COUNT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!start) begin
            // Idle, hold at zero
            count <= '0;
        end else if (done) begin
            // Wrap so a held start gives a periodic done
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

/* rtl/button_conditioner.sv */
`timescale 1ns/1ps

module button_conditioner #(
    parameter int unsigned DEBOUNCE_LEN = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic btn,
    output logic pulse
);

    ////////////////////////////////
    // Debounce
    ////////////////////////////////

    // Newest sample in bit 0
    logic [DEBOUNCE_LEN-1:0] samples;
    logic [DEBOUNCE_LEN:0]   shifted;
    logic                    stable;
    logic                    stable_d;

    assign shifted = {samples, btn};

    // Accepted only after a full window of highs
    assign stable = &samples;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            samples <= '0;
        end else begin
            samples <= shifted[DEBOUNCE_LEN-1:0];
        end
    end

    ////////////////////////////////
    // One pulse
    ////////////////////////////////

    // Rising edge of the debounced level
    // Level must drop before the next pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stable_d <= 1'b0;
            pulse    <= 1'b0;
        end else begin
            stable_d <= stable;
            pulse    <= stable & ~stable_d;
        end
    end

endmodule

/* rtl/seg_display.sv */
`timescale 1ns/1ps

module seg_display import link_pkg::*, board_pkg::*; (
    input  link_data_t digit,
    output seg_t       seg
);

    onehot_digit_t onehot;

    // Binary digit to one line per value
    assign onehot = onehot_digit_t'(1) << digit;

    ////////////////////////////////
    // Segment map
    ////////////////////////////////

    // Segment is dark (high) for every digit listed
    always_comb begin
        // a, off for 1 and 4
        seg[0] = onehot[1] | onehot[4];
        // b, off for 5 and 6
        seg[1] = onehot[5] | onehot[6];
        // c, off for 2 only
        seg[2] = onehot[2];
        // d
        seg[3] = onehot[1] | onehot[4] | onehot[7];
        // e, lower left, lit only on 0, 2, 6
        seg[4] = onehot[1] | onehot[3] | onehot[4] | onehot[5] | onehot[7];
        // f
        seg[5] = onehot[1] | onehot[2] | onehot[3] | onehot[7];
        // g, middle bar
        seg[6] = onehot[0] | onehot[1] | onehot[7];
    end

endmodule

/* master/switch_encoder.sv */
`timescale 1ns/1ps

module switch_encoder import link_pkg::*, board_pkg::*; (
    input  switch_t    switches,
    output link_data_t digit
);

    // Index of the single set switch
    // Zero or several set switches fall back to 0
    always_comb begin
        case (switches)
            8'b0000_0001: digit = 3'd0;
            8'b0000_0010: digit = 3'd1;
            8'b0000_0100: digit = 3'd2;
            8'b0000_1000: digit = 3'd3;
            8'b0001_0000: digit = 3'd4;
            8'b0010_0000: digit = 3'd5;
            8'b0100_0000: digit = 3'd6;
            8'b1000_0000: digit = 3'd7;
            // Not one-hot
            default:      digit = 3'd0;
        endcase
    end

endmodule

/* master/master_control.sv */
`timescale 1ns/1ps

module master_control import link_pkg::*; #(
    parameter int unsigned HOLD_CYCLES = 100_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       request,
    input  logic       ack,
    input  link_data_t switch_digit,
    output logic       request2s,
    output logic       valid,
    output logic       notice,
    output link_data_t data
);

    master_state_t state;
    master_state_t next_state;
    logic          next_request2s;
    logic          next_valid;
    logic          next_notice;
    link_data_t    next_data;

    // Hold timer control
    logic timer_start;
    logic next_timer_start;
    logic timer_done;

    hold_timer #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_hold_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    ////////////////////////////////
    // State and output registers
    ////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= M_WAIT_RQST;
            request2s   <= 1'b0;
            valid       <= 1'b0;
            notice      <= 1'b0;
            data        <= '0;
            timer_start <= 1'b0;
        end else begin
            state       <= next_state;
            request2s   <= next_request2s;
            valid       <= next_valid;
            notice      <= next_notice;
            data        <= next_data;
            timer_start <= next_timer_start;
        end
    end

    ////////////////////////////////
    // Next state logic
    ////////////////////////////////

    always_comb begin
        next_state       = state;
        next_request2s   = request2s;
        next_valid       = valid;
        next_notice      = notice;
        next_data        = data;
        next_timer_start = timer_start;
        case (state)
            M_WAIT_RQST: begin
                // Button pulse only counts here
                if (request) begin
                    next_state     = M_WAIT_ACK;
                    next_request2s = 1'b1;
                end
            end
            M_WAIT_ACK: begin
                // Request seen by slave, light the notice
                if (ack) begin
                    next_state       = M_HOLD_NOTICE;
                    next_request2s   = 1'b0;
                    next_notice      = 1'b1;
                    next_timer_start = 1'b1;
                end
            end
            M_HOLD_NOTICE: begin
                // Switches sampled once, at the end of the hold
                if (timer_done) begin
                    next_state       = M_SEND_DATA;
                    next_notice      = 1'b0;
                    next_timer_start = 1'b0;
                    next_valid       = 1'b1;
                    next_data        = switch_digit;
                end
            end
            M_SEND_DATA: begin
                // Keep data stable until the receipt ack
                if (ack) begin
                    next_state = M_WAIT_RQST;
                    next_valid = 1'b0;
                    next_data  = '0;
                end
            end
            default: begin
                next_state = M_WAIT_RQST;
            end
        endcase
    end

endmodule

/* slave/slave_control.sv */
`timescale 1ns/1ps

module slave_control import link_pkg::*; #(
    parameter int unsigned HOLD_CYCLES = 100_000_000
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       request,
    input  logic       valid,
    input  link_data_t data_in,
    output logic       ack,
    output logic       notice,
    output link_data_t digit
);

    slave_state_t state;
    slave_state_t next_state;
    logic         next_ack;
    logic         next_notice;
    link_data_t   next_digit;

    logic timer_start;
    logic next_timer_start;
    logic timer_done;

    hold_timer #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_hold_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (timer_start),
        .done  (timer_done)
    );

    ////////////////////////////////
    // State and output registers
    ////////////////////////////////

    // Digit register drives the display, so it clears to 0
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= S_WAIT_RQST;
            ack         <= 1'b0;
            notice      <= 1'b0;
            digit       <= '0;
            timer_start <= 1'b0;
        end else begin
            state       <= next_state;
            ack         <= next_ack;
            notice      <= next_notice;
            digit       <= next_digit;
            timer_start <= next_timer_start;
        end
    end

    ////////////////////////////////
    // Next state logic
    ////////////////////////////////

    always_comb begin
        next_state       = state;
        // Ack is a one cycle strobe
        next_ack         = 1'b0;
        next_notice      = notice;
        next_digit       = digit;
        next_timer_start = timer_start;
        case (state)
            S_WAIT_RQST: begin
                if (request) begin
                    next_state       = S_HOLD_NOTICE;
                    next_notice      = 1'b1;
                    next_timer_start = 1'b1;
                end
            end
            S_HOLD_NOTICE: begin
                // First ack, request seen
                if (timer_done) begin
                    next_state       = S_WAIT_DATA;
                    next_notice      = 1'b0;
                    next_timer_start = 1'b0;
                    next_ack         = 1'b1;
                end
            end
            S_WAIT_DATA: begin
                // Second ack, data latched
                if (valid) begin
                    next_state = S_WAIT_RQST;
                    next_digit = data_in;
                    next_ack   = 1'b1;
                end
            end
            default: begin
                next_state = S_WAIT_RQST;
            end
        endcase
    end

endmodule

/* rtl/chip_link_top.sv */
`timescale 1ns/1ps

module chip_link_top import link_pkg::*, board_pkg::*; #(
    parameter int unsigned HOLD_CYCLES  = 100_000_000,
    parameter int unsigned DEBOUNCE_LEN = 4
) (
    input  logic       clk,
    input  logic       rst_n,
    input  switch_t    switches,
    input  logic       request_btn,
    output logic       notice_master,
    output logic       notice_slave,
    output logic       request2s,
    output logic       ack,
    output logic       valid,
    output link_data_t link_data,
    output seg_t       seven_seg
);

    logic       request_pulse;
    link_data_t switch_digit;
    link_data_t slave_digit;

    ////////////////////////////////
    // Master board
    ////////////////////////////////

    button_conditioner #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) u_button_conditioner (
        .clk   (clk),
        .rst_n (rst_n),
        .btn   (request_btn),
        .pulse (request_pulse)
    );

    switch_encoder u_switch_encoder (
        .switches (switches),
        .digit    (switch_digit)
    );

    master_control #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_master_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .request      (request_pulse),
        .ack          (ack),
        .switch_digit (switch_digit),
        .request2s    (request2s),
        .valid        (valid),
        .notice       (notice_master),
        .data         (link_data)
    );

    ////////////////////////////////
    // Slave board
    ////////////////////////////////

    // Link wires run straight across
    slave_control #(
        .HOLD_CYCLES (HOLD_CYCLES)
    ) u_slave_control (
        .clk     (clk),
        .rst_n   (rst_n),
        .request (request2s),
        .valid   (valid),
        .data_in (link_data),
        .ack     (ack),
        .notice  (notice_slave),
        .digit   (slave_digit)
    );

    seg_display u_seg_display (
        .digit (slave_digit),
        .seg   (seven_seg)
    );

endmodule

/* tb/chip_link_tb.sv */
`timescale 1ns/1ps

module chip_link_tb import link_pkg::*, board_pkg::*; ();

    localparam int HOLD_CYCLES  = 6;
    localparam int DEBOUNCE_LEN = 4;
    localparam int CLK_PERIOD   = 100;
    // About 20 transfers of 40 cycles plus margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk = 1'b0;
    logic       rst_n;
    switch_t    switches;
    logic       request_btn;
    logic       notice_master;
    logic       notice_slave;
    logic       request2s;
    logic       ack;
    logic       valid;
    link_data_t link_data;
    seg_t       seven_seg;

    // Reference model state
    int         cycle_count;
    int         press_left;
    int         rise_count;
    int         transfers_done;
    int         slave_run;
    int         master_run;
    link_data_t expected_digit;
    link_data_t shown_digit;
    logic       prev_ack;
    logic       prev_request2s;
    logic       prev_valid;
    logic       prev_notice_slave;
    logic       prev_notice_master;
    link_data_t prev_link_data;

    chip_link_top #(
        .HOLD_CYCLES  (HOLD_CYCLES),
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) u_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .switches      (switches),
        .request_btn   (request_btn),
        .notice_master (notice_master),
        .notice_slave  (notice_slave),
        .request2s     (request2s),
        .ack           (ack),
        .valid         (valid),
        .link_data     (link_data),
        .seven_seg     (seven_seg)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////
    // Reference rules
    //////////////////////////////

    // Exactly one set switch gives its index and anything else gives 0
    function automatic link_data_t encode_switches(input switch_t sw);
        int i;
        int ones;
        int index;
        ones  = 0;
        index = 0;
        for (i = 0; i < 8; i++) begin
            if (sw[i]) begin
                ones++;
                index = i;
            end
        end
        return (ones == 1) ? link_data_t'(index) : link_data_t'(0);
    endfunction

    // Active low with bit 0 as segment a and bit 6 as segment g
    function automatic seg_t seg_pattern(input link_data_t d);
        case (d)
            3'd0:    return 7'h40;
            3'd1:    return 7'h79;
            3'd2:    return 7'h24;
            3'd3:    return 7'h30;
            3'd4:    return 7'h19;
            3'd5:    return 7'h12;
            3'd6:    return 7'h02;
            default: return 7'h78;
        endcase
    endfunction

    task automatic fail_value(input string name, input int expected, input int actual);
        $display("error at %0t: %s expected 'h%0h actual 'h%0h", $time, name, expected, actual);
        $display("TESTS FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic fail_text(input string what);
        $display("error at %0t: %s", $time, what);
        $display("TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    //////////////////////////////
    // Link checks
    //////////////////////////////

    // Both acks are single cycle strobes
    ack_is_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) !(ack && $past(ack))
    ) else fail_text("ack stayed high for more than one cycle");

    // Request and data phases never overlap
    phases_apart: assert property (
        @(posedge clk) disable iff (!rst_n) !(request2s && valid)
    ) else fail_text("request2s and valid high together");

    // Registered outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rst_n) begin
            // Slave notice length and the first ack at its fall
            if (notice_slave) begin
                slave_run++;
            end else if (prev_notice_slave) begin
                assert (slave_run == HOLD_CYCLES + 1)
                    else fail_value("notice_slave length", HOLD_CYCLES + 1, slave_run);
                assert (ack) else fail_value("ack", 1, int'(ack));
                slave_run = 0;
            end
            // Master notice length and valid at its fall
            if (notice_master) begin
                master_run++;
            end else if (prev_notice_master) begin
                assert (master_run == HOLD_CYCLES + 1)
                    else fail_value("notice_master length", HOLD_CYCLES + 1, master_run);
                assert (valid) else fail_value("valid", 1, int'(valid));
                master_run = 0;
            end
            if (request2s && !prev_request2s) begin
                rise_count++;
            end
            // request2s drops only once ack was seen
            if (!request2s && prev_request2s) begin
                assert (prev_ack)
                    else fail_value("ack before request2s fall", 1, int'(prev_ack));
            end
            if (valid && !prev_valid) begin
                assert (link_data == expected_digit)
                    else fail_value("link_data", int'(expected_digit), int'(link_data));
            end else if (valid) begin
                // Held stable for the whole data phase
                assert (link_data == prev_link_data)
                    else fail_value("link_data", int'(prev_link_data), int'(link_data));
            end else begin
                assert (link_data == '0) else fail_value("link_data", 0, int'(link_data));
                if (prev_valid) begin
                    assert (prev_ack)
                        else fail_value("ack before valid fall", 1, int'(prev_ack));
                end
            end
            // Display takes the new digit on the receipt ack
            if (valid && ack) begin
                shown_digit = expected_digit;
                transfers_done++;
            end
            assert (seven_seg == seg_pattern(shown_digit))
                else fail_value("seven_seg", int'(seg_pattern(shown_digit)), int'(seven_seg));
        end
        prev_ack           = ack;
        prev_request2s     = request2s;
        prev_valid         = valid;
        prev_notice_slave  = notice_slave;
        prev_notice_master = notice_master;
        prev_link_data     = link_data;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            fail_text("timeout, transfers did not finish within the cycle limit");
        end
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    // Advance one cycle and release the button when its press runs out
    task automatic next_cycle();
        @(negedge clk);
        if (press_left > 0) begin
            press_left--;
            if (press_left == 0) begin
                request_btn = 1'b0;
            end
        end
    endtask

    task automatic check_idle();
        assert (!request2s) else fail_value("request2s", 0, int'(request2s));
        assert (!valid) else fail_value("valid", 0, int'(valid));
        assert (!ack) else fail_value("ack", 0, int'(ack));
        assert (!notice_master) else fail_value("notice_master", 0, int'(notice_master));
        assert (!notice_slave) else fail_value("notice_slave", 0, int'(notice_slave));
        assert (link_data == '0) else fail_value("link_data", 0, int'(link_data));
        assert (seven_seg == seg_pattern(3'd0))
            else fail_value("seven_seg", int'(seg_pattern(3'd0)), int'(seven_seg));
    endtask

    // Presses shorter than the debounce window
    task automatic short_presses();
        int n;
        int len;
        for (n = 0; n < 6; n++) begin
            if (n == 0) begin
                len = DEBOUNCE_LEN - 1;
            end else begin
                len = 1 + int'($urandom % (DEBOUNCE_LEN - 1));
            end
            request_btn = 1'b1;
            repeat (len) @(negedge clk);
            request_btn = 1'b0;
            repeat (2) @(negedge clk);
        end
        repeat (8) @(negedge clk);
        assert (rise_count == 0) else fail_value("request2s rise count", 0, rise_count);
    endtask

    task automatic do_transfer(input switch_t sw, input link_data_t exp, input int press);
        int rises_before;
        int done_before;
        rises_before   = rise_count;
        done_before    = transfers_done;
        expected_digit = exp;
        switches       = sw;
        request_btn    = 1'b1;
        press_left     = press;
        while (!valid) begin
            next_cycle();
        end
        // Captured digit must ignore later switch moves
        switches = switch_t'($urandom);
        while (transfers_done == done_before) begin
            next_cycle();
        end
        while (valid) begin
            next_cycle();
        end
        // Let a long press run out before some idle time
        while (press_left > 0) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        assert (rise_count == rises_before + 1)
            else fail_value("request2s rise count", rises_before + 1, rise_count);
        assert (seven_seg == seg_pattern(exp))
            else fail_value("seven_seg", int'(seg_pattern(exp)), int'(seven_seg));
    endtask

    initial begin
        int n;
        int idx;
        logic [7:0] seen;
        void'($urandom(32'h3364));
        rst_n          = 1'b0;
        request_btn    = 1'b0;
        switches       = '0;
        cycle_count    = 0;
        press_left     = 0;
        rise_count     = 0;
        transfers_done = 0;
        slave_run      = 0;
        master_run     = 0;
        expected_digit = '0;
        shown_digit    = '0;
        seen           = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_idle();

        short_presses();

        // One long press gives one transfer
        do_transfer(8'b0010_0000, encode_switches(8'b0010_0000), 60);

        // Vectors that are not one-hot give digit 0
        do_transfer(8'h00, encode_switches(8'h00), 6);
        do_transfer(8'b1001_0000, encode_switches(8'b1001_0000), 6);
        do_transfer(8'hff, encode_switches(8'hff), 6);

        for (n = 0; n < 12; n++) begin
            // Every index comes up once before any repeat
            idx = int'($urandom % 8);
            while (n < 8 && seen[idx]) begin
                idx = int'($urandom % 8);
            end
            seen[idx] = 1'b1;
            do_transfer(switch_t'(1) << idx, link_data_t'(idx), 6);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* vlog.f */
common/link_pkg.sv
common/board_pkg.sv
rtl/hold_timer.sv
rtl/button_conditioner.sv
rtl/seg_display.sv
master/switch_encoder.sv
master/master_control.sv
slave/slave_control.sv
rtl/chip_link_top.sv
tb/chip_link_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module chip_link_tb -o chip_link_sim
	./obj_dir/chip_link_sim

clean:
	rm -rf obj_dir
